//--- hw/qsim_pkg.sv
package qsim_pkg;

    localparam int SAMPLE_W = 16;
    localparam int ACC_W    = 32;
    localparam int WORD_W   = 32;
    localparam int CMD_W    = 64;
    localparam int ENV_AW   = 10;
    localparam int CMD_AW   = 6;
    localparam int ACC_AW   = 6;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [ACC_W-1:0]    acc_t;
    typedef logic [WORD_W-1:0]          word_t;
    typedef logic [CMD_W-1:0]           cmd_t;
    typedef logic [ENV_AW-1:0]          env_addr_t;
    typedef logic [CMD_AW-1:0]          cmd_addr_t;
    typedef logic [ACC_AW-1:0]          acc_addr_t;

    // the low host word sits in bits 31..0 of a command.
    localparam int CMD_ENV_LSB  = 0;
    localparam int CMD_LEN_LSB  = 16;
    localparam int CMD_LEN_W    = 8;
    localparam int CMD_GAIN_LSB = 32;
    localparam int CMD_LAST_BIT = 63;

    localparam logic [2:0] SEL_CMD = 3'd0;
    localparam logic [2:0] SEL_ENV = 3'd1;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        PLAY,
        DRAIN,
        STORE
    } core_state_e;

endpackage

//--- hw/aligned_ram.sv
`timescale 1ns/1ps

module aligned_ram import qsim_pkg::*; #(
    parameter int N_DIN_TO_DOUT   = 1,
    parameter int DOUT_ADDR_WIDTH = 10,
    parameter int READ_LATENCY    = 2
) (
    input  logic                                              clk,
    input  word_t                                             write_data,
    input  logic [DOUT_ADDR_WIDTH+$clog2(N_DIN_TO_DOUT)-1:0]  write_addr,
    input  logic                                              write_enable,
    input  logic [DOUT_ADDR_WIDTH-1:0]                        read_addr,
    output logic [32*N_DIN_TO_DOUT-1:0]                       read_data
);

    localparam int DEPTH = N_DIN_TO_DOUT * (2 ** DOUT_ADDR_WIDTH);
    localparam int DW    = 32 * N_DIN_TO_DOUT;

    logic [31:0]      mem [0:DEPTH-1];
    logic [DEPTH-1:0] written;
    logic [DW-1:0]    rd_word;
    logic [DW-1:0]    pipe [0:READ_LATENCY-1];

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_addr]     <= write_data;
            written[write_addr] <= 1'b1;
        end
    end

    // lowest word address lands in the low bits.
    always_comb begin
        for (int n = 0; n < N_DIN_TO_DOUT; n++) begin
            rd_word[32*n +: 32] = mem[int'(read_addr) * N_DIN_TO_DOUT + n];
        end
    end

    always_ff @(posedge clk) begin
        pipe[0] <= rd_word;
        for (int k = 1; k < READ_LATENCY; k++) begin
            pipe[k] <= pipe[k-1];
        end
    end

    assign read_data = pipe[READ_LATENCY-1];

    // every word of a written location reads back known.
    a_read_known: assert property (@(posedge clk)
        (&written[int'(read_addr) * N_DIN_TO_DOUT +: N_DIN_TO_DOUT]) === 1'b1
            |-> ##READ_LATENCY !$isunknown(read_data));

endmodule

//--- hw/env_arbiter.sv
`timescale 1ns/1ps

module env_arbiter import qsim_pkg::*; #(
    parameter int NPROC = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [NPROC-1:0] env_req,
    input  env_addr_t        env_addr [0:NPROC-1],
    output logic [NPROC-1:0] env_gnt,
    output env_addr_t        ram_addr,
    input  sample_t          ram_data,
    output sample_t          env_rdata,
    output logic [NPROC-1:0] env_rvalid
);

    localparam int IW = (NPROC > 1) ? $clog2(NPROC) : 1;

    logic [IW-1:0]    last_idx;
    logic [IW-1:0]    win_idx;
    logic [NPROC-1:0] tag_d1;
    logic [NPROC-1:0] tag_d2;

    // scanning from far to near lets the nearest requester after last_idx win.
    always_comb begin
        int idx;
        env_gnt = '0;
        win_idx = '0;
        for (int k = NPROC; k >= 1; k--) begin
            idx = (int'(last_idx) + k) % NPROC;
            if (env_req[idx]) begin
                env_gnt      = '0;
                env_gnt[idx] = 1'b1;
                win_idx      = IW'(idx);
            end
        end
    end

    assign ram_addr = env_addr[win_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_idx <= IW'(NPROC - 1); // core 0 goes first.
            tag_d1   <= '0;
            tag_d2   <= '0;
        end else begin
            if (|env_gnt) begin
                last_idx <= win_idx;
            end
            tag_d1 <= env_gnt;
            tag_d2 <= tag_d1;   // matches ram read latency.
        end
    end

    assign env_rvalid = tag_d2;
    assign env_rdata  = ram_data;

    a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(env_gnt));
    a_gnt_to_req: assert property (@(posedge clk) disable iff (!rst_n)
        (env_gnt & ~env_req) == '0);
    a_rvalid_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(env_rvalid));

endmodule

//--- hw/pulse_core.sv
`timescale 1ns/1ps

module pulse_core import qsim_pkg::*; #(
    parameter int NPROC = 2
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stb_start,
    input  word_t     nshot,
    output cmd_addr_t cmd_addr,
    input  cmd_t      cmd_data,
    output logic      env_req,
    output env_addr_t env_addr,
    input  logic      env_gnt,
    input  logic      env_rvalid,
    input  sample_t   env_rdata,
    input  sample_t   adc,
    output sample_t   dac,
    output logic      dac_valid,
    output logic      busy,
    output logic      acc_we,
    output acc_addr_t acc_waddr,
    output acc_t      acc_wdata
);

    core_state_e           state;
    cmd_addr_t             cmd_idx;
    word_t                 shot_cnt;
    acc_addr_t             pulse_cnt;
    logic                  fetch_wait;
    logic [CMD_LEN_W-1:0]  gnt_cnt;
    logic [1:0]            outstanding;
    acc_t                  acc;
    env_addr_t             cmd_env;
    logic [CMD_LEN_W-1:0]  cmd_len;
    sample_t               cmd_gain;
    logic                  cmd_last;
    logic                  last_gnt;
    logic signed [31:0]    product;

    // cmd_addr is held from FETCH to STORE, so the fields stay valid.
    assign cmd_env  = cmd_data[CMD_ENV_LSB +: ENV_AW];
    assign cmd_len  = cmd_data[CMD_LEN_LSB +: CMD_LEN_W];
    assign cmd_gain = cmd_data[CMD_GAIN_LSB +: SAMPLE_W];
    assign cmd_last = cmd_data[CMD_LAST_BIT];

    assign cmd_addr = cmd_idx;
    assign env_req  = (state == PLAY);
    assign env_addr = cmd_env + env_addr_t'(gnt_cnt); // steps on grants only.
    assign last_gnt = env_gnt && (gnt_cnt == cmd_len - 1'b1);

    assign product   = env_rdata * cmd_gain;
    assign dac       = sample_t'(product >>> 15);
    assign dac_valid = env_rvalid;
    assign busy      = (state != IDLE);

    assign acc_we    = (state == STORE);
    assign acc_waddr = pulse_cnt;
    assign acc_wdata = acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            cmd_idx    <= '0;
            shot_cnt   <= '0;
            pulse_cnt  <= '0;
            fetch_wait <= 1'b0;
            gnt_cnt    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (stb_start) begin
                        state      <= FETCH;
                        cmd_idx    <= '0;
                        shot_cnt   <= '0;
                        pulse_cnt  <= '0;
                        fetch_wait <= 1'b0;
                    end
                end
                FETCH: begin
                    fetch_wait <= 1'b1;
                    gnt_cnt    <= '0;
                    if (fetch_wait) begin
                        state <= PLAY;  // cmd_data valid from here.
                    end
                end
                PLAY: begin
                    if (env_gnt) begin
                        gnt_cnt <= gnt_cnt + 1'b1;
                        if (last_gnt) begin
                            state <= DRAIN;
                        end
                    end
                end
                DRAIN: begin
                    if (outstanding == {1'b0, env_rvalid}) begin
                        state <= STORE;
                    end
                end
                STORE: begin
                    pulse_cnt  <= pulse_cnt + 1'b1;
                    fetch_wait <= 1'b0;
                    state      <= FETCH;
                    if (!cmd_last) begin
                        cmd_idx <= cmd_idx + 1'b1;
                    end else if (shot_cnt + 1'b1 < nshot) begin
                        cmd_idx  <= '0; // next shot.
                        shot_cnt <= shot_cnt + 1'b1;
                    end else begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + {1'b0, env_gnt} - {1'b0, env_rvalid};
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH) begin
            acc <= '0;
        end else if (env_rvalid) begin
            acc <= acc + acc_t'(adc);
        end
    end

    a_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding <= 2'd2);
    a_dac_state: assert property (@(posedge clk) disable iff (!rst_n)
        dac_valid |-> (state == PLAY || state == DRAIN));
    // round robin serves every waiting core within NPROC cycles.
    a_gnt_fair: assert property (@(posedge clk) disable iff (!rst_n)
        env_req |-> ##[0:NPROC-1] env_gnt);

endmodule

//--- hw/qsim_top.sv
`timescale 1ns/1ps

module qsim_top import qsim_pkg::*; #(
    parameter int NPROC = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stb_start,
    input  word_t            nshot,
    input  word_t            mem_write_data,
    input  logic [15:0]      mem_write_addr,
    input  logic [2:0]       proc_write_sel,
    input  logic [2:0]       mem_write_sel,
    input  logic             mem_write_en,
    input  acc_addr_t        buf_read_addr,
    input  sample_t          adc [0:NPROC-1],
    output sample_t          dac [0:NPROC-1],
    output logic [NPROC-1:0] dac_valid,
    output logic [NPROC-1:0] busy,
    output acc_t             acc_read_data [0:NPROC-1]
);

    logic             env_we;
    logic [31:0]      env_ram_data;
    env_addr_t        env_ram_addr;
    logic [NPROC-1:0] env_req;
    logic [NPROC-1:0] env_gnt;
    logic [NPROC-1:0] env_rvalid;
    env_addr_t        env_addr [0:NPROC-1];
    sample_t          env_rdata;

    // the one envelope memory ignores proc_write_sel.
    assign env_we = mem_write_en && (mem_write_sel == SEL_ENV);

    aligned_ram #(.N_DIN_TO_DOUT(1), .DOUT_ADDR_WIDTH(ENV_AW), .READ_LATENCY(2))
        i_env_mem (.clk(clk), .write_data(mem_write_data),
            .write_addr(mem_write_addr[ENV_AW-1:0]), .write_enable(env_we),
            .read_addr(env_ram_addr), .read_data(env_ram_data));

    env_arbiter #(.NPROC(NPROC))
        i_env_arbiter (.clk(clk), .rst_n(rst_n), .env_req(env_req), .env_addr(env_addr),
            .env_gnt(env_gnt), .ram_addr(env_ram_addr),
            .ram_data(env_ram_data[SAMPLE_W-1:0]), .env_rdata(env_rdata),
            .env_rvalid(env_rvalid));

    for (genvar i = 0; i < NPROC; i++) begin : g_core
        logic      cmd_we;
        cmd_addr_t cmd_addr;
        cmd_t      cmd_data;
        logic      acc_we;
        acc_addr_t acc_waddr;
        acc_t      acc_wdata;

        assign cmd_we = mem_write_en && (mem_write_sel == SEL_CMD)
                        && (proc_write_sel == 3'(i));

        aligned_ram #(.N_DIN_TO_DOUT(2), .DOUT_ADDR_WIDTH(CMD_AW), .READ_LATENCY(2))
            i_cmd_mem (.clk(clk), .write_data(mem_write_data),
                .write_addr(mem_write_addr[CMD_AW:0]), .write_enable(cmd_we),
                .read_addr(cmd_addr), .read_data(cmd_data));

        pulse_core #(.NPROC(NPROC))
            i_pulse_core (.clk(clk), .rst_n(rst_n), .stb_start(stb_start), .nshot(nshot),
                .cmd_addr(cmd_addr), .cmd_data(cmd_data),
                .env_req(env_req[i]), .env_addr(env_addr[i]), .env_gnt(env_gnt[i]),
                .env_rvalid(env_rvalid[i]), .env_rdata(env_rdata), .adc(adc[i]),
                .dac(dac[i]), .dac_valid(dac_valid[i]), .busy(busy[i]),
                .acc_we(acc_we), .acc_waddr(acc_waddr), .acc_wdata(acc_wdata));

        aligned_ram #(.N_DIN_TO_DOUT(1), .DOUT_ADDR_WIDTH(ACC_AW), .READ_LATENCY(1))
            i_acc_buf (.clk(clk), .write_data(word_t'(acc_wdata)),
                .write_addr(acc_waddr), .write_enable(acc_we),
                .read_addr(buf_read_addr), .read_data(acc_read_data[i]));
    end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1; // released on an edge.
    end

endmodule

//--- tests/qsim_tb.sv
`timescale 1ns/1ps

module qsim_tb import qsim_pkg::*; ();

    localparam int NPROC    = 2;
    localparam int MAX_CMDS = 8;

    logic             clk;
    logic             rst_n;
    logic             stb_start;
    word_t            nshot;
    word_t            mem_write_data;
    logic [15:0]      mem_write_addr;
    logic [2:0]       proc_write_sel;
    logic [2:0]       mem_write_sel;
    logic             mem_write_en;
    acc_addr_t        buf_read_addr;
    sample_t          adc [0:NPROC-1];
    sample_t          dac [0:NPROC-1];
    logic [NPROC-1:0] dac_valid;
    logic [NPROC-1:0] busy;
    acc_t             acc_read_data [0:NPROC-1];

    sample_t          env_model [0:1023];
    int               n_cmds [0:NPROC-1];
    env_addr_t        cmd_env [0:NPROC-1][0:MAX_CMDS-1];
    int               cmd_len [0:NPROC-1][0:MAX_CMDS-1];
    sample_t          cmd_gain [0:NPROC-1][0:MAX_CMDS-1];
    sample_t          exp_q [0:NPROC-1][$];
    acc_t             acc_q [0:NPROC-1][$];
    sample_t          exp_head [0:NPROC-1];
    int               exp_left [0:NPROC-1];
    acc_t             acc_exp [0:NPROC-1];
    logic [NPROC-1:0] acc_check;
    logic             started;
    bit               wd_armed;
    int               wd_limit;

    tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(8)) i_tb_clock (.clk(clk), .rst_n(rst_n));

    qsim_top #(.NPROC(NPROC)) i_qsim_top (
        .clk(clk), .rst_n(rst_n), .stb_start(stb_start), .nshot(nshot),
        .mem_write_data(mem_write_data), .mem_write_addr(mem_write_addr),
        .proc_write_sel(proc_write_sel), .mem_write_sel(mem_write_sel),
        .mem_write_en(mem_write_en), .buf_read_addr(buf_read_addr), .adc(adc),
        .dac(dac), .dac_valid(dac_valid), .busy(busy), .acc_read_data(acc_read_data)
    );

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic report_value(input string name, input longint expected, input longint actual);
        fail_run($sformatf("ERR %0t %s expected %0d actual %0d", $time, name, expected, actual));
    endtask

    // gain is q1.15, so the product comes back down by 15 bits.
    function automatic sample_t scale_sample(input sample_t env, input sample_t gain);
        int product;
        product = int'(env) * int'(gain);
        return sample_t'(product >>> 15);
    endfunction

    task automatic host_write(input logic [2:0] msel, input logic [2:0] psel,
                              input logic [15:0] addr, input word_t data);
        @(posedge clk);
        mem_write_sel  <= msel;
        proc_write_sel <= psel;
        mem_write_addr <= addr;
        mem_write_data <= data;
        mem_write_en   <= 1'b1;
    endtask

    task automatic load_envelope();
        for (int a = 0; a < 1024; a++) begin
            env_model[a] = sample_t'($urandom);
            host_write(SEL_ENV, 3'd0, 16'(a), {16'h0000, env_model[a]});
        end
        @(posedge clk);
        mem_write_en <= 1'b0;
    endtask

    task automatic random_list(input int core, input int count, input int min_len,
                               input int max_len);
        n_cmds[core] = count;
        for (int k = 0; k < count; k++) begin
            cmd_len[core][k]  = $urandom_range(max_len, min_len);
            cmd_env[core][k]  = env_addr_t'($urandom_range(1023 - cmd_len[core][k]));
            cmd_gain[core][k] = sample_t'($urandom);
        end
    endtask

    task automatic load_commands(input int core);
        logic last;
        for (int k = 0; k < n_cmds[core]; k++) begin
            last = (k == n_cmds[core] - 1);
            host_write(SEL_CMD, 3'(core), 16'(2 * k),
                {8'h00, 8'(cmd_len[core][k]), 6'h00, cmd_env[core][k]});
            host_write(SEL_CMD, 3'(core), 16'(2 * k + 1),
                {last, 15'h0000, cmd_gain[core][k]});
        end
    endtask

    task automatic read_acc(input int core, input int k, input acc_t expected);
        @(posedge clk);
        buf_read_addr <= acc_addr_t'(k);
        @(posedge clk);
        acc_exp[core]   <= expected;
        acc_check[core] <= 1'b1;   // data is out one cycle after the address.
        @(posedge clk);
        acc_check[core] <= 1'b0;
    endtask

    task automatic run_and_check(input int shots, input bit restart);
        sample_t av [0:NPROC-1];
        int      total;
        total = 0;
        for (int c = 0; c < NPROC; c++) begin
            av[c] = sample_t'($urandom);
            load_commands(c);
            for (int sh = 0; sh < shots; sh++) begin
                for (int k = 0; k < n_cmds[c]; k++) begin
                    for (int s = 0; s < cmd_len[c][k]; s++) begin
                        exp_q[c].push_back(
                            scale_sample(env_model[int'(cmd_env[c][k]) + s], cmd_gain[c][k]));
                    end
                    total += cmd_len[c][k];
                    acc_q[c].push_back(acc_t'(cmd_len[c][k]) * acc_t'(av[c]));
                end
            end
        end
        @(posedge clk);
        mem_write_en <= 1'b0;
        nshot        <= word_t'(shots);
        for (int c = 0; c < NPROC; c++) begin
            adc[c] <= av[c];
        end
        repeat (2) @(posedge clk);
        wd_limit = 3 * total * NPROC + 2000;
        wd_armed = 1'b1;
        stb_start <= 1'b1;
        started   <= 1'b1;
        @(posedge clk);
        stb_start <= 1'b0;
        if (restart) begin
            repeat (20) @(posedge clk);
            stb_start <= 1'b1;  // cores are busy here.
            @(posedge clk);
            stb_start <= 1'b0;
        end
        do begin
            @(posedge clk);
        end while (busy != '0);
        wd_armed = 1'b0;
        for (int c = 0; c < NPROC; c++) begin
            for (int k = 0; k < acc_q[c].size(); k++) begin
                read_acc(c, k, acc_q[c][k]);
            end
            acc_q[c].delete();
        end
    endtask

    always @(posedge clk) begin
        for (int c = 0; c < NPROC; c++) begin
            if (dac_valid[c] && exp_q[c].size() > 0) begin
                void'(exp_q[c].pop_front());
            end
            exp_left[c] <= exp_q[c].size();
            exp_head[c] <= (exp_q[c].size() > 0) ? exp_q[c][0] : '0;
        end
    end

    a_busy_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> busy == '0)
        else report_value("busy", 0, $sampled(busy));
    a_valid_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> dac_valid == '0)
        else report_value("dac_valid", 0, $sampled(dac_valid));
    a_gnt_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> i_qsim_top.env_gnt == '0)
        else report_value("env_gnt", 0, $sampled(i_qsim_top.env_gnt));

    for (genvar i = 0; i < NPROC; i++) begin : g_check
        a_dac_expected: assert property (@(posedge clk) disable iff (!rst_n)
            dac_valid[i] |-> exp_left[i] > 0)
            else fail_run($sformatf("core %0d played a sample that was never queued", i));
        a_dac_value: assert property (@(posedge clk) disable iff (!rst_n)
            dac_valid[i] && exp_left[i] > 0 |-> dac[i] == exp_head[i])
            else report_value($sformatf("dac[%0d]", i), $sampled(exp_head[i]),
                $sampled(dac[i]));
        a_no_loss: assert property (@(posedge clk) disable iff (!rst_n)
            $fell(busy[i]) |-> exp_left[i] == 0)
            else fail_run($sformatf("core %0d went idle with samples still unplayed", i));
        a_busy_start: assert property (@(posedge clk) disable iff (!rst_n)
            $rose(busy[i]) |-> $past(stb_start))
            else fail_run($sformatf("core %0d became busy without a start strobe", i));
        a_acc_value: assert property (@(posedge clk) disable iff (!rst_n)
            acc_check[i] |-> acc_read_data[i] == acc_exp[i])
            else report_value($sformatf("acc_read_data[%0d] at %0d", i,
                $sampled(buf_read_addr)), $sampled(acc_exp[i]), $sampled(acc_read_data[i]));
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (!(wd_armed && cycles > wd_limit)) begin
            @(posedge clk);
            cycles = wd_armed ? cycles + 1 : 0;
        end
        fail_run("timeout: cores never went idle");
    end

    initial begin
        void'($urandom(32'h39cf_5965));
        stb_start      <= 1'b0;
        nshot          <= '0;
        mem_write_data <= '0;
        mem_write_addr <= '0;
        proc_write_sel <= '0;
        mem_write_sel  <= '0;
        mem_write_en   <= 1'b0;
        buf_read_addr  <= '0;
        acc_check      <= '0;
        started        <= 1'b0;
        for (int c = 0; c < NPROC; c++) begin
            adc[c] <= '0;
        end
        wait (rst_n === 1'b1);
        repeat (4) @(posedge clk);
        load_envelope();
        repeat (2) begin
            random_list(0, 6, 1, 40); // core 1 plays one short pulse.
            random_list(1, 1, 1, 1);
            run_and_check(1, 1'b0);
        end
        random_list(0, 3, 100, 255);
        random_list(1, 3, 100, 255);
        run_and_check(1, 1'b0);
        random_list(0, 4, 5, 30);
        random_list(1, 2, 10, 50);
        run_and_check(3, 1'b1);
        repeat (10) @(posedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- qsim.f
hw/qsim_pkg.sv
hw/aligned_ram.sv
hw/env_arbiter.sv
hw/pulse_core.sv
hw/qsim_top.sv
tests/tb_clock.sv
tests/qsim_tb.sv

//--- Bender.yml
package:
  name: qsim

sources:
  - hw/qsim_pkg.sv
  - hw/aligned_ram.sv
  - hw/env_arbiter.sv
  - hw/pulse_core.sv
  - hw/qsim_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/qsim_tb.sv
